// ==== src/afifo_cfg.svh ====
`ifndef AFIFO_CFG_SVH
`define AFIFO_CFG_SVH

// payload width in bits
`define AFIFO_DATA_W 8

// number of entries as a power of two so that the gray pointers wrap cleanly
`define AFIFO_DEPTH 16

// afull is raised once the fill level reaches this value
`define AFIFO_AFULL (`AFIFO_DEPTH - 2)

// aempty is raised while the fill level is at or below this value
`define AFIFO_AEMPTY 2

`endif

// ==== src/afifo_ptr_pkg.sv ====
`include "afifo_cfg.svh"

package afifo_ptr_pkg;

  localparam int ADDR_W = $clog2(`AFIFO_DEPTH);

  typedef logic [ADDR_W-1:0] addr_t; // ram index
  typedef logic [ADDR_W:0]   ptr_t;  // index plus the wrap bit

  function automatic ptr_t bin2gray(input ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  // each binary bit is the xor of all gray bits at and above it
  function automatic ptr_t gray2bin(input ptr_t gray);
    ptr_t bin;
    bin[ADDR_W] = gray[ADDR_W];
    for (int i = ADDR_W - 1; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

// ==== src/afifo_data_pkg.sv ====
`include "afifo_cfg.svh"

package afifo_data_pkg;

  // one payload word as stored in the ram
  typedef logic [`AFIFO_DATA_W-1:0] data_t;

endpackage

// ==== src/afifo_ptr_if.sv ====
`timescale 1ns/1ps

interface afifo_ptr_if;
  import afifo_ptr_pkg::*;

  ptr_t  wr_ptr_gray; // registered on wr_clk and only read through a synchronizer
  ptr_t  rd_ptr_gray; // registered on rd_clk and read the same way
  addr_t wr_addr;
  logic  wr_fire;
  addr_t rd_addr;
  logic  rd_fire;

  modport wr_side (
    output wr_ptr_gray,
    output wr_addr,
    output wr_fire,
    input  rd_ptr_gray
  );

  modport rd_side (
    output rd_ptr_gray,
    output rd_addr,
    output rd_fire,
    input  wr_ptr_gray
  );

  // the ram only needs the addresses and the strobes
  modport ram_side (
    input wr_addr,
    input wr_fire,
    input rd_addr,
    input rd_fire
  );

endinterface

// ==== src/afifo_dpram.sv ====
`timescale 1ns/1ps
`include "afifo_cfg.svh"

module afifo_dpram (
  input  logic                  wr_clk,
  input  logic                  rd_clk,
  input  logic                  wr_rst_n,
  input  afifo_data_pkg::data_t wr_data,
  afifo_ptr_if.ram_side         ptr,
  output afifo_data_pkg::data_t rd_data
);
  import afifo_data_pkg::*;

  data_t mem [`AFIFO_DEPTH];

  always_ff @(posedge wr_clk) begin
    if (ptr.wr_fire) begin
      mem[ptr.wr_addr] <= wr_data;
    end
  end

  // the output register holds the last word read until the next accepted read
  always_ff @(posedge rd_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      rd_data <= '0;
    end else if (ptr.rd_fire) begin
      rd_data <= mem[ptr.rd_addr]; // address is the pointer before it advances
    end
  end

endmodule

// ==== src/afifo_wr_ctrl.sv ====
`timescale 1ns/1ps
`include "afifo_cfg.svh"

module afifo_wr_ctrl (
  input  logic         wr_clk,
  input  logic         wr_rst_n,
  input  logic         wr_en,
  afifo_ptr_if.wr_side ptr,
  output logic         full,
  output logic         afull
);
  import afifo_ptr_pkg::*;

  ptr_t wr_bin;
  ptr_t wr_bin_nxt;
  ptr_t wr_gray_nxt;
  ptr_t rd_gray_s1;
  ptr_t rd_gray_s2;
  ptr_t rd_bin_sync;
  ptr_t wr_level;
  logic wr_fire;
  logic full_nxt;
  logic afull_nxt;

  assign wr_fire = wr_en & ~full; // writes while full are dropped

  assign wr_bin_nxt  = wr_fire ? wr_bin + 1'b1 : wr_bin;
  assign wr_gray_nxt = bin2gray(wr_bin_nxt);

  assign ptr.wr_addr = wr_bin[ADDR_W-1:0];
  assign ptr.wr_fire = wr_fire;

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_bin          <= '0;
      ptr.wr_ptr_gray <= '0;
    end else begin
      wr_bin          <= wr_bin_nxt;
      ptr.wr_ptr_gray <= wr_gray_nxt; // straight from a flop, so only one bit moves per step
    end
  end

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      rd_gray_s1 <= '0;
      rd_gray_s2 <= '0;
    end else begin
      rd_gray_s1 <= ptr.rd_ptr_gray;
      rd_gray_s2 <= rd_gray_s1;
    end
  end

  assign rd_bin_sync = gray2bin(rd_gray_s2);

  // the synchronized read pointer lags, so the level here can only be too high
  assign wr_level = wr_bin_nxt - rd_bin_sync;

  // full means the write side is exactly one lap ahead of the read side
  assign full_nxt  = wr_gray_nxt == {~rd_gray_s2[ADDR_W:ADDR_W-1], rd_gray_s2[ADDR_W-2:0]};
  assign afull_nxt = wr_level >= `AFIFO_AFULL;

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      full  <= 1'b0;
      afull <= 1'b0;
    end else begin
      full  <= full_nxt;
      afull <= afull_nxt;
    end
  end

endmodule

// ==== src/afifo_rd_ctrl.sv ====
`timescale 1ns/1ps
`include "afifo_cfg.svh"

module afifo_rd_ctrl (
  input  logic         rd_clk,
  input  logic         wr_rst_n,
  input  logic         rd_en,
  afifo_ptr_if.rd_side ptr,
  output logic         empty,
  output logic         aempty
);
  import afifo_ptr_pkg::*;

  ptr_t rd_bin;
  ptr_t rd_bin_nxt;
  ptr_t rd_gray_nxt;
  ptr_t wr_gray_s1;
  ptr_t wr_gray_s2;
  ptr_t wr_bin_sync;
  ptr_t rd_level;
  logic rd_fire;
  logic empty_nxt;
  logic aempty_nxt;

  assign rd_fire = rd_en & ~empty; // nothing is taken from an empty fifo

  assign rd_bin_nxt  = rd_fire ? rd_bin + 1'b1 : rd_bin;
  assign rd_gray_nxt = bin2gray(rd_bin_nxt);

  assign ptr.rd_addr = rd_bin[ADDR_W-1:0];
  assign ptr.rd_fire = rd_fire;

  always_ff @(posedge rd_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      rd_bin          <= '0;
      ptr.rd_ptr_gray <= '0;
    end else begin
      rd_bin          <= rd_bin_nxt;
      ptr.rd_ptr_gray <= rd_gray_nxt;
    end
  end

  // two flops on rd_clk before the write pointer is used here
  always_ff @(posedge rd_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_gray_s1 <= '0;
      wr_gray_s2 <= '0;
    end else begin
      wr_gray_s1 <= ptr.wr_ptr_gray;
      wr_gray_s2 <= wr_gray_s1;
    end
  end

  assign wr_bin_sync = gray2bin(wr_gray_s2);

  assign rd_level = wr_bin_sync - rd_bin_nxt; // may read low while new writes cross over

  assign empty_nxt  = rd_gray_nxt == wr_gray_s2;
  assign aempty_nxt = rd_level <= `AFIFO_AEMPTY;

  always_ff @(posedge rd_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      empty  <= 1'b1;
      aempty <= 1'b1;
    end else begin
      empty  <= empty_nxt;
      aempty <= aempty_nxt;
    end
  end

endmodule

// ==== src/afifo_top.sv ====
`timescale 1ns/1ps

module afifo_top (
  input  logic                  wr_clk,
  input  logic                  wr_rst_n,
  input  logic                  wr_en,
  input  afifo_data_pkg::data_t wr_data,
  input  logic                  rd_clk,
  input  logic                  rd_en,
  output afifo_data_pkg::data_t rd_data,
  output logic                  full,
  output logic                  empty,
  output logic                  afull,
  output logic                  aempty
);

  // pointers and ram strobes between the two controllers and the storage
  afifo_ptr_if i_ptr ();

  afifo_wr_ctrl i_wr (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .ptr      (i_ptr.wr_side),
    .full     (full),
    .afull    (afull)
  );

  // the read side runs off the same reset as the write side
  afifo_rd_ctrl i_rd (
    .rd_clk   (rd_clk),
    .wr_rst_n (wr_rst_n),
    .rd_en    (rd_en),
    .ptr      (i_ptr.rd_side),
    .empty    (empty),
    .aempty   (aempty)
  );

  afifo_dpram i_ram (
    .wr_clk   (wr_clk),
    .rd_clk   (rd_clk),
    .wr_rst_n (wr_rst_n),
    .wr_data  (wr_data),
    .ptr      (i_ptr.ram_side),
    .rd_data  (rd_data)
  );

endmodule

// ==== verif/afifo_checker.sv ====
`timescale 1ns/1ps

module afifo_checker (
  input logic wr_clk,
  input logic rd_clk,
  input logic wr_rst_n,
  input logic full,
  input logic afull,
  input logic empty,
  input logic aempty
);

  int fails = 0;

  // full comes from the write domain and is sampled here on the read clock
  a_full_empty_excl: assert property (
    @(posedge rd_clk) disable iff (!wr_rst_n) !(full && empty)
  ) else begin
    fails++;
    $error("full and empty are high in the same cycle");
  end

  a_afull_covers_full: assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n) full |-> afull
  ) else begin
    fails++;
    $error("full is high while afull is low");
  end

  a_aempty_covers_empty: assert property (
    @(posedge rd_clk) disable iff (!wr_rst_n) empty |-> aempty
  ) else begin
    fails++;
    $error("empty is high while aempty is low");
  end

  a_reset_values: assert property (
    @(posedge rd_clk) !wr_rst_n |-> (!full && !afull && empty && aempty)
  ) else begin
    fails++;
    $error("flags left their reset values while reset was asserted");
  end

endmodule

bind afifo_top afifo_checker i_chk (
  .wr_clk   (wr_clk),
  .rd_clk   (rd_clk),
  .wr_rst_n (wr_rst_n),
  .full     (full),
  .afull    (afull),
  .empty    (empty),
  .aempty   (aempty)
);

// ==== verif/afifo_monitor.sv ====
`timescale 1ns/1ps
`include "afifo_cfg.svh"

module afifo_monitor (
  input  logic                  wr_clk,
  input  logic                  rd_clk,
  input  logic                  wr_rst_n,
  input  logic                  wr_en,
  input  afifo_data_pkg::data_t wr_data,
  input  logic                  rd_en,
  input  afifo_data_pkg::data_t rd_data,
  input  logic                  full,
  input  logic                  afull,
  input  logic                  empty,
  input  logic                  aempty,
  output int                    errors,
  output int                    checks
);
  import afifo_data_pkg::*;

  data_t model_q [$]; // accepted writes that have not been read yet
  data_t exp_word;
  logic  pending = 1'b0;
  int    reported = 0;
  int    reads = 0;

  initial begin
    errors = 0;
    checks = 0;
  end

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERROR at %0t ns: %s expected 0x%0h, actual 0x%0h",
               $time, name, expected, actual);
    end
  endtask

  always @(posedge wr_clk) begin
    if (wr_rst_n && wr_en && !full) begin
      model_q.push_back(wr_data);
    end
  end

  // rd_data of an accepted read is compared on the following rd_clk edge
  always @(posedge rd_clk) begin
    if (pending) begin
      compare_value("rd_data", 32'(exp_word), 32'(rd_data));
      pending = 1'b0;
    end
    if (wr_rst_n && rd_en && !empty) begin
      if (model_q.size() == 0) begin
        errors++;
        $display("read accepted at %0t ns although no written word was left to read", $time);
      end else begin
        exp_word = model_q.pop_front();
        pending  = 1'b1;
        reads++;
      end
    end
  end

  task automatic check_reset();
    compare_value("full", 32'd0, 32'(full));
    compare_value("afull", 32'd0, 32'(afull));
    compare_value("empty", 32'd1, 32'(empty));
    compare_value("aempty", 32'd1, 32'(aempty));
    compare_value("rd_data", 32'd0, 32'(rd_data));
    $display("reset check finished with %0d errors", errors - reported);
    reported = errors;
  endtask

  // exp_flags holds full, afull, empty, aempty from msb to lsb
  task automatic check_idle(input int idx, input logic [3:0] exp_flags);
    int level;
    level = model_q.size();
    compare_value("full", 32'(exp_flags[3]), 32'(full));
    compare_value("afull", 32'(exp_flags[2]), 32'(afull));
    compare_value("empty", 32'(exp_flags[1]), 32'(empty));
    compare_value("aempty", 32'(exp_flags[0]), 32'(aempty));
    compare_value("afull", 32'(level >= `AFIFO_AFULL), 32'(afull)); // level rule on its own
    compare_value("aempty", 32'(level <= `AFIFO_AEMPTY), 32'(aempty));
    $display("test %0d finished: level %0d, %0d reads so far, %s",
             idx, level, reads, (errors == reported) ? "ok" : "failed");
    reported = errors;
  endtask

endmodule

// ==== verif/afifo_tb.sv ====
`timescale 1ns/1ps
`include "afifo_cfg.svh"

module afifo_tb;
  import afifo_data_pkg::*;

  localparam int RD_PERIOD = 100;
  localparam int WR_PERIOD = 70;
  localparam int NUM_TESTS = 13;
  localparam int SETTLE    = 4; // idle cycles on each clock before the flags are compared

  localparam logic [1:0] GAP_NONE    = 2'd0; // one word per cycle
  localparam logic [1:0] GAP_RAND    = 2'd1; // 0 to 3 idle cycles after each word
  localparam logic [1:0] IGNORE_FLAG = 2'd2; // strobes the enable whatever full or empty say

  typedef struct packed {
    int         wr_cnt;
    int         rd_cnt;
    logic [1:0] wr_mode;
    logic [1:0] rd_mode;
    logic [3:0] flags; // full, afull, empty, aempty once both sides are idle
  } test_t;

  test_t tests [NUM_TESTS] = '{
    '{ 0,  0, GAP_NONE,    GAP_NONE,    4'b0011},
    '{ 5,  0, GAP_RAND,    GAP_NONE,    4'b0000},
    '{ 3,  6, GAP_RAND,    GAP_RAND,    4'b0001},
    '{12,  0, GAP_NONE,    GAP_NONE,    4'b0100},
    '{ 2,  0, GAP_NONE,    GAP_NONE,    4'b1100},
    '{ 1,  0, IGNORE_FLAG, GAP_NONE,    4'b1100}, // write while full is dropped
    '{ 0, 16, GAP_NONE,    GAP_RAND,    4'b0011},
    '{ 0,  3, GAP_NONE,    IGNORE_FLAG, 4'b0011}, // reads while empty accept nothing
    '{40, 40, GAP_RAND,    GAP_RAND,    4'b0011},
    '{30, 27, GAP_NONE,    GAP_RAND,    4'b0000},
    '{20, 23, GAP_RAND,    GAP_NONE,    4'b0011},
    '{15,  0, GAP_RAND,    GAP_NONE,    4'b0100},
    '{ 0, 15, GAP_NONE,    GAP_NONE,    4'b0011}
  };

  logic        wr_clk = 1'b1; // starts high so falling edges of the two clocks never meet
  logic        rd_clk = 1'b0;
  logic        wr_rst_n;
  logic        wr_en;
  logic        rd_en;
  data_t       wr_data;
  data_t       rd_data;
  logic        full;
  logic        empty;
  logic        afull;
  logic        aempty;
  int          mon_errors;
  int          mon_checks;
  logic [15:0] lfsr_state = 16'd5;

  always #(WR_PERIOD / 2) wr_clk = ~wr_clk;
  always #(RD_PERIOD / 2) rd_clk = ~rd_clk;

  afifo_top i_dut (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .full     (full),
    .empty    (empty),
    .afull    (afull),
    .aempty   (aempty)
  );

  afifo_monitor i_mon (
    .wr_clk   (wr_clk),
    .rd_clk   (rd_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .full     (full),
    .afull    (afull),
    .empty    (empty),
    .aempty   (aempty),
    .errors   (mon_errors),
    .checks   (mon_checks)
  );

  // galois form with taps 16, 14, 13 and 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[14:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  function automatic int total_words();
    int sum;
    sum = 0;
    foreach (tests[i]) begin
      sum += tests[i].wr_cnt + tests[i].rd_cnt;
    end
    return sum;
  endfunction

  task automatic write_words(input int count, input logic [1:0] mode);
    int          sent;
    logic [15:0] bits;
    sent = 0;
    while (sent < count) begin
      @(negedge wr_clk);
      if (mode != IGNORE_FLAG && full) begin
        wr_en = 1'b0; // full seen here is what the next rising edge samples
      end else begin
        take_bits(`AFIFO_DATA_W, bits);
        wr_data = data_t'(bits);
        wr_en   = 1'b1;
        sent++;
        if (mode == GAP_RAND) begin
          take_bits(2, bits);
          repeat (bits) begin
            @(negedge wr_clk);
            wr_en = 1'b0;
          end
        end
      end
    end
    @(negedge wr_clk);
    wr_en = 1'b0;
  endtask

  task automatic read_words(input int count, input logic [1:0] mode);
    int          taken;
    logic [15:0] bits;
    taken = 0;
    while (taken < count) begin
      @(negedge rd_clk);
      if (mode != IGNORE_FLAG && empty) begin
        rd_en = 1'b0;
      end else begin
        rd_en = 1'b1;
        taken++;
        if (mode == GAP_RAND) begin
          take_bits(2, bits);
          repeat (bits) begin
            @(negedge rd_clk);
            rd_en = 1'b0;
          end
        end
      end
    end
    @(negedge rd_clk);
    rd_en = 1'b0;
  endtask

  initial begin
    wr_rst_n = 1'b1;
    wr_en    = 1'b0;
    rd_en    = 1'b0;
    wr_data  = '0;
    #10 wr_rst_n = 1'b0;
    repeat (10) @(negedge rd_clk);
    i_mon.check_reset();
    wr_rst_n = 1'b1;
    for (int t = 0; t < NUM_TESTS; t++) begin
      fork
        write_words(tests[t].wr_cnt, tests[t].wr_mode);
        read_words(tests[t].rd_cnt, tests[t].rd_mode);
      join
      repeat (SETTLE) @(negedge wr_clk);
      repeat (SETTLE) @(negedge rd_clk);
      i_mon.check_idle(t, tests[t].flags);
    end
    $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
             NUM_TESTS, mon_checks, mon_errors, i_dut.i_chk.fails);
    if (mon_errors == 0 && i_dut.i_chk.fails == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // each word may take up to 4 slow cycles, plus settling time per test and the reset
  initial begin
    longint limit;
    limit = 64'(total_words()) * 4 * RD_PERIOD + 64'(NUM_TESTS) * 2000 + 5000;
    #(limit);
    $display("the run timed out after %0d ns before all tests had finished", limit);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+src
src/afifo_ptr_pkg.sv
src/afifo_data_pkg.sv
src/afifo_ptr_if.sv
src/afifo_dpram.sv
src/afifo_wr_ctrl.sv
src/afifo_rd_ctrl.sv
src/afifo_top.sv
verif/afifo_checker.sv
verif/afifo_monitor.sv
verif/afifo_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module afifo_tb --Mdir obj_dir -o afifo_sim -f all.f
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

sim_out=$(./obj_dir/afifo_sim +verilator+error+limit+1000)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "TEST RESULT: PASS" <<< "$sim_out"; then
  exit 0
fi
echo "pass message not found in the simulation output"
exit 1
